// ==== include/vout_defines.svh ====
/*
 * Width and limit macros for the output video stage
 */

`ifndef VOUT_DEFINES_SVH
`define VOUT_DEFINES_SVH

// One colour component towards HDMI TX and VGA DAC
`define VOUT_PIX_W 8

// OSD fill colour, one bit each for R, G and B
`define VOUT_OSD_COLOR_W 3

// Frames without genlock before resync is flagged
// saturates at all ones
`define VOUT_RESYNC_CNT_W 3

`endif

// ==== hw/vout_pkg.sv ====
/*
 * Output stage types: pixel component, OSD colour, resync count,
 * composite sync, expansion port and extra output mode enums
 */

`include "vout_defines.svh"

package vout_pkg;

    typedef logic [`VOUT_PIX_W-1:0] pix_t;

    // Bit 2 is R, bit 1 is G, bit 0 is B
    typedef logic [`VOUT_OSD_COLOR_W-1:0] osd_color_t;

    typedef logic [`VOUT_RESYNC_CNT_W-1:0] resync_cnt_t;

    typedef enum logic {
        CSYNC_AND  = 1'b0,
        CSYNC_XNOR = 1'b1
    } csync_mode_e;

    // Only EXP_EXTRA_OUT drives the VGA DAC
    typedef enum logic [1:0] {
        EXP_OFF       = 2'd0,
        EXP_EXTRA_OUT = 2'd1,
        EXP_LEGACY_IN = 2'd2,
        EXP_UVC_BDG   = 2'd3
    } exp_sel_e;

    typedef enum logic [1:0] {
        EXTRA_RGBHV = 2'd0,
        EXTRA_RGBCS = 2'd1,
        EXTRA_RGSB  = 2'd2,
        EXTRA_YPBPR = 2'd3
    } extra_mode_e;

endpackage

// ==== hw/vout_cfg_regs.sv ====
/*
 * Output configuration registers loaded by a four-phase req/ack handshake
 */

`timescale 1ns/100ps

module vout_cfg_regs (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic                   cfg_req_i,
    input  logic                   cfg_hdmi_csync_i,
    input  vout_pkg::csync_mode_e  cfg_csync_mode_i,
    input  vout_pkg::exp_sel_e     cfg_exp_sel_i,
    input  vout_pkg::extra_mode_e  cfg_extra_mode_i,
    output logic                   cfg_ack_o,
    output logic                   hdmi_csync_o,
    output vout_pkg::csync_mode_e  csync_mode_o,
    output vout_pkg::exp_sel_e     exp_sel_o,
    output vout_pkg::extra_mode_e  extra_mode_o
);

    logic load;

    // New request only, so data is taken once per handshake
    assign load = cfg_req_i & ~cfg_ack_o;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cfg_ack_o <= 1'b0;
        end else if (load) begin
            cfg_ack_o <= 1'b1;
        end else if (!cfg_req_i) begin
            cfg_ack_o <= 1'b0;
        end
    end

    // Active configuration, takes effect with the rising ack
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_csync_o <= 1'b0;
            csync_mode_o <= vout_pkg::CSYNC_AND;
            exp_sel_o    <= vout_pkg::EXP_OFF;
            extra_mode_o <= vout_pkg::EXTRA_RGBHV;
        end else if (load) begin
            hdmi_csync_o <= cfg_hdmi_csync_i;
            csync_mode_o <= cfg_csync_mode_i;
            exp_sel_o    <= cfg_exp_sel_i;
            extra_mode_o <= cfg_extra_mode_i;
        end
    end

endmodule

// ==== hw/osd_overlay.sv ====
/*
 * First output register stage with OSD fill colour replacement
 */

`timescale 1ns/100ps

`include "vout_defines.svh"

module osd_overlay (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  vout_pkg::pix_t        r_i,
    input  vout_pkg::pix_t        g_i,
    input  vout_pkg::pix_t        b_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic                  de_i,
    input  logic                  osd_enable_i,
    input  vout_pkg::osd_color_t  osd_color_i,
    output vout_pkg::pix_t        r_o,
    output vout_pkg::pix_t        g_o,
    output vout_pkg::pix_t        b_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o
);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
        end else begin
            if (osd_enable_i) begin
                // Each component saturates to full scale or black
                r_o <= {`VOUT_PIX_W{osd_color_i[2]}};
                g_o <= {`VOUT_PIX_W{osd_color_i[1]}};
                b_o <= {`VOUT_PIX_W{osd_color_i[0]}};
            end else begin
                r_o <= r_i;
                g_o <= g_i;
                b_o <= b_i;
            end
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= de_i;
        end
    end

endmodule

// ==== hw/hdmi_tx_out.sv ====
/*
 * HDMI transmitter output register stage with optional composite sync on HSYNC
 */

`timescale 1ns/100ps

module hdmi_tx_out (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  vout_pkg::pix_t         r_i,
    input  vout_pkg::pix_t         g_i,
    input  vout_pkg::pix_t         b_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   de_i,
    input  logic                   hdmi_csync_i,
    input  vout_pkg::csync_mode_e  csync_mode_i,
    output vout_pkg::pix_t         hdmitx_r_o,
    output vout_pkg::pix_t         hdmitx_g_o,
    output vout_pkg::pix_t         hdmitx_b_o,
    output logic                   hdmitx_hsync_o,
    output logic                   hdmitx_vsync_o,
    output logic                   hdmitx_de_o
);

    logic csync;

    // Active-low syncs: AND merges pulses, XNOR inverts hsync inside vsync
    assign csync = (csync_mode_i == vout_pkg::CSYNC_AND) ? (hsync_i & vsync_i)
                                                         : ~(hsync_i ^ vsync_i);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmitx_r_o     <= '0;
            hdmitx_g_o     <= '0;
            hdmitx_b_o     <= '0;
            hdmitx_hsync_o <= 1'b1;
            hdmitx_vsync_o <= 1'b1;
            hdmitx_de_o    <= 1'b0;
        end else begin
            hdmitx_r_o     <= r_i;
            hdmitx_g_o     <= g_i;
            hdmitx_b_o     <= b_i;
            hdmitx_hsync_o <= hdmi_csync_i ? csync : hsync_i;
            hdmitx_vsync_o <= vsync_i;
            hdmitx_de_o    <= de_i;
        end
    end

endmodule

// ==== hw/vga_dac_out.sv ====
/*
 * Two-stage VGA DAC formatter for RGBHV, RGBCS and RGsB sync modes
 */

`timescale 1ns/100ps

module vga_dac_out (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  vout_pkg::pix_t         r_i,
    input  vout_pkg::pix_t         g_i,
    input  vout_pkg::pix_t         b_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   de_i,
    input  vout_pkg::exp_sel_e     exp_sel_i,
    input  vout_pkg::extra_mode_e  extra_mode_i,
    input  vout_pkg::csync_mode_e  csync_mode_i,
    output vout_pkg::pix_t         vga_r_o,
    output vout_pkg::pix_t         vga_g_o,
    output vout_pkg::pix_t         vga_b_o,
    output logic                   vga_hs_o,
    output logic                   vga_vs_o,
    output logic                   vga_blank_n_o,
    output logic                   vga_sync_n_o,
    output logic                   vga_oe_o
);

    logic           vga_en;
    logic           csync;
    logic           mode_hv;
    logic           mode_sog;
    vout_pkg::pix_t r_pre;
    vout_pkg::pix_t g_pre;
    vout_pkg::pix_t b_pre;
    logic           hs_pre;
    logic           vs_pre;
    logic           blank_n_pre;
    logic           sync_n_pre;

    assign vga_en   = (exp_sel_i == vout_pkg::EXP_EXTRA_OUT);
    assign vga_oe_o = vga_en;

    assign csync = (csync_mode_i == vout_pkg::CSYNC_AND) ? (hsync_i & vsync_i)
                                                         : ~(hsync_i ^ vsync_i);

    assign mode_hv = (extra_mode_i == vout_pkg::EXTRA_RGBHV);
    // YPbPr code gets sync on green too
    assign mode_sog = (extra_mode_i == vout_pkg::EXTRA_RGSB) ||
                      (extra_mode_i == vout_pkg::EXTRA_YPBPR);

    // Stage 1, sync formatting
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            r_pre       <= '0;
            g_pre       <= '0;
            b_pre       <= '0;
            hs_pre      <= 1'b1;
            vs_pre      <= 1'b1;
            blank_n_pre <= 1'b0;
            sync_n_pre  <= 1'b0;
        end else if (vga_en) begin
            r_pre       <= r_i;
            g_pre       <= g_i;
            b_pre       <= b_i;
            hs_pre      <= mode_hv ? hsync_i : csync;
            vs_pre      <= mode_hv ? vsync_i : 1'b1;
            blank_n_pre <= de_i;
            sync_n_pre  <= mode_sog ? csync : 1'b0;
        end
    end

    // Stage 2, DAC pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_r_o       <= '0;
            vga_g_o       <= '0;
            vga_b_o       <= '0;
            vga_hs_o      <= 1'b1;
            vga_vs_o      <= 1'b1;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (vga_en) begin
            vga_r_o       <= r_pre;
            vga_g_o       <= g_pre;
            vga_b_o       <= b_pre;
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

endmodule

// ==== hw/resync_monitor.sv ====
/*
 * Saturating count of output frames started without a genlock pulse
 */

`timescale 1ns/100ps

module resync_monitor (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic                   out_sof_i,
    input  logic                   genlock_sof_i,
    output vout_pkg::resync_cnt_t  resync_cnt_o,
    output logic                   resync_o
);

    logic sof_prev;
    logic sof_fall;

    assign sof_fall = sof_prev & ~out_sof_i;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sof_prev     <= 1'b0;
            resync_cnt_o <= '0;
        end else begin
            sof_prev <= out_sof_i;
            if (sof_fall) begin
                if (genlock_sof_i) begin
                    resync_cnt_o <= '0;
                end else if (resync_cnt_o != '1) begin
                    resync_cnt_o <= resync_cnt_o + 1'b1;
                end
            end
        end
    end

    // Flag stays up while saturated
    assign resync_o = (resync_cnt_o == '1);

endmodule

// ==== hw/vout_top.sv ====
/*
 * Output video stage top: config registers, OSD overlay, HDMI and VGA
 * output paths, and the genlock resync monitor
 */

`timescale 1ns/100ps

module vout_top (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  vout_pkg::pix_t         r_i,
    input  vout_pkg::pix_t         g_i,
    input  vout_pkg::pix_t         b_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   de_i,
    input  logic                   osd_enable_i,
    input  vout_pkg::osd_color_t   osd_color_i,
    input  logic                   cfg_req_i,
    input  logic                   cfg_hdmi_csync_i,
    input  vout_pkg::csync_mode_e  cfg_csync_mode_i,
    input  vout_pkg::exp_sel_e     cfg_exp_sel_i,
    input  vout_pkg::extra_mode_e  cfg_extra_mode_i,
    output logic                   cfg_ack_o,
    input  logic                   out_sof_i,
    input  logic                   genlock_sof_i,
    output vout_pkg::pix_t         hdmitx_r_o,
    output vout_pkg::pix_t         hdmitx_g_o,
    output vout_pkg::pix_t         hdmitx_b_o,
    output logic                   hdmitx_hsync_o,
    output logic                   hdmitx_vsync_o,
    output logic                   hdmitx_de_o,
    output vout_pkg::pix_t         vga_r_o,
    output vout_pkg::pix_t         vga_g_o,
    output vout_pkg::pix_t         vga_b_o,
    output logic                   vga_hs_o,
    output logic                   vga_vs_o,
    output logic                   vga_blank_n_o,
    output logic                   vga_sync_n_o,
    output logic                   vga_oe_o,
    output vout_pkg::resync_cnt_t  resync_cnt_o,
    output logic                   resync_o
);

    logic                  hdmi_csync;
    vout_pkg::csync_mode_e csync_mode;
    vout_pkg::exp_sel_e    exp_sel;
    vout_pkg::extra_mode_e extra_mode;

    // Overlay stage output, shared by HDMI and VGA paths
    vout_pkg::pix_t        r_out;
    vout_pkg::pix_t        g_out;
    vout_pkg::pix_t        b_out;
    logic                  hsync_out;
    logic                  vsync_out;
    logic                  de_out;

    vout_cfg_regs u_cfg_regs (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .cfg_req_i        (cfg_req_i),
        .cfg_hdmi_csync_i (cfg_hdmi_csync_i),
        .cfg_csync_mode_i (cfg_csync_mode_i),
        .cfg_exp_sel_i    (cfg_exp_sel_i),
        .cfg_extra_mode_i (cfg_extra_mode_i),
        .cfg_ack_o        (cfg_ack_o),
        .hdmi_csync_o     (hdmi_csync),
        .csync_mode_o     (csync_mode),
        .exp_sel_o        (exp_sel),
        .extra_mode_o     (extra_mode)
    );

    osd_overlay u_osd_overlay (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .hsync_i      (hsync_i),
        .vsync_i      (vsync_i),
        .de_i         (de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .r_o          (r_out),
        .g_o          (g_out),
        .b_o          (b_out),
        .hsync_o      (hsync_out),
        .vsync_o      (vsync_out),
        .de_o         (de_out)
    );

    hdmi_tx_out u_hdmi_tx_out (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .r_i            (r_out),
        .g_i            (g_out),
        .b_i            (b_out),
        .hsync_i        (hsync_out),
        .vsync_i        (vsync_out),
        .de_i           (de_out),
        .hdmi_csync_i   (hdmi_csync),
        .csync_mode_i   (csync_mode),
        .hdmitx_r_o     (hdmitx_r_o),
        .hdmitx_g_o     (hdmitx_g_o),
        .hdmitx_b_o     (hdmitx_b_o),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    vga_dac_out u_vga_dac_out (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .r_i           (r_out),
        .g_i           (g_out),
        .b_i           (b_out),
        .hsync_i       (hsync_out),
        .vsync_i       (vsync_out),
        .de_i          (de_out),
        .exp_sel_i     (exp_sel),
        .extra_mode_i  (extra_mode),
        .csync_mode_i  (csync_mode),
        .vga_r_o       (vga_r_o),
        .vga_g_o       (vga_g_o),
        .vga_b_o       (vga_b_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o),
        .vga_oe_o      (vga_oe_o)
    );

    resync_monitor u_resync_monitor (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .out_sof_i     (out_sof_i),
        .genlock_sof_i (genlock_sof_i),
        .resync_cnt_o  (resync_cnt_o),
        .resync_o      (resync_o)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
/*
 * Testbench clock and reset source
 */

`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2.0) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== test/tb_vout_top.sv ====
/*
 * Testbench for vout_top: random video stream, config handshake,
 * reference model with history queue, resync monitor frames
 */

`timescale 1ns/100ps

module tb_vout_top;

    localparam int n_osd     = 300;
    localparam int n_csync   = 150;
    localparam int n_vga     = 150;
    localparam int n_hold    = 100;
    localparam int ack_limit = 16;
    // Reset, streams with their handshakes, handshake test, resync frames
    localparam int run_cycles = 20 + n_osd + 4 * (n_csync + 10) + 4 * (n_vga + 10)
                                + n_hold + 10 + 20 + 12 * 6;
    localparam int timeout_cycles = 2 * run_cycles;

    typedef struct packed {
        vout_pkg::pix_t       r, g, b;
        logic                 hs, vs, de, osd_en;
        vout_pkg::osd_color_t osd_color;
    } sample_t;

    typedef struct packed {
        vout_pkg::pix_t r, g, b;
        logic           hdmi_hs, hdmi_vs, de;
        logic           vga_hs, vga_vs, vga_blank_n, vga_sync_n;
    } expect_t;

    logic pclk_out;
    logic po_reset_n;
    vout_pkg::pix_t r_i, g_i, b_i;
    logic hsync_i, vsync_i, de_i, osd_enable_i;
    vout_pkg::osd_color_t osd_color_i;
    logic cfg_req_i, cfg_hdmi_csync_i, cfg_ack_o;
    vout_pkg::csync_mode_e cfg_csync_mode_i;
    vout_pkg::exp_sel_e cfg_exp_sel_i;
    vout_pkg::extra_mode_e cfg_extra_mode_i;
    logic out_sof_i, genlock_sof_i;
    vout_pkg::pix_t hdmitx_r_o, hdmitx_g_o, hdmitx_b_o;
    logic hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o;
    vout_pkg::pix_t vga_r_o, vga_g_o, vga_b_o;
    logic vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o, vga_oe_o;
    vout_pkg::resync_cnt_t resync_cnt_o;
    logic resync_o;

    int errors, test_errors, tests_run, tests_failed, cycle_cnt;
    int unsigned seed_val;
    logic chk_hdmi, chk_vga;
    // Expected configuration as loaded by the handshake
    logic m_hdmi_csync;
    vout_pkg::csync_mode_e m_csync_mode;
    vout_pkg::exp_sel_e m_exp_sel;
    vout_pkg::extra_mode_e m_extra_mode;
    vout_pkg::resync_cnt_t m_resync_cnt;
    sample_t hist[$];
    sample_t cur_sample;
    expect_t hdmi_exp, vga_exp;
    vout_pkg::pix_t hold_r, hold_g, hold_b;
    logic hold_hs, hold_vs, hold_blank_n, hold_sync_n;

    tb_clk_gen u_clk_gen (.clk_o(pclk_out), .rst_n_o(po_reset_n));

    vout_top u_vout_top (
        .pclk_out(pclk_out), .po_reset_n(po_reset_n),
        .r_i(r_i), .g_i(g_i), .b_i(b_i),
        .hsync_i(hsync_i), .vsync_i(vsync_i), .de_i(de_i),
        .osd_enable_i(osd_enable_i), .osd_color_i(osd_color_i),
        .cfg_req_i(cfg_req_i), .cfg_hdmi_csync_i(cfg_hdmi_csync_i),
        .cfg_csync_mode_i(cfg_csync_mode_i), .cfg_exp_sel_i(cfg_exp_sel_i),
        .cfg_extra_mode_i(cfg_extra_mode_i), .cfg_ack_o(cfg_ack_o),
        .out_sof_i(out_sof_i), .genlock_sof_i(genlock_sof_i),
        .hdmitx_r_o(hdmitx_r_o), .hdmitx_g_o(hdmitx_g_o), .hdmitx_b_o(hdmitx_b_o),
        .hdmitx_hsync_o(hdmitx_hsync_o), .hdmitx_vsync_o(hdmitx_vsync_o),
        .hdmitx_de_o(hdmitx_de_o),
        .vga_r_o(vga_r_o), .vga_g_o(vga_g_o), .vga_b_o(vga_b_o),
        .vga_hs_o(vga_hs_o), .vga_vs_o(vga_vs_o), .vga_blank_n_o(vga_blank_n_o),
        .vga_sync_n_o(vga_sync_n_o), .vga_oe_o(vga_oe_o),
        .resync_cnt_o(resync_cnt_o), .resync_o(resync_o)
    );

    function automatic expect_t ref_outputs(sample_t s, logic hdmi_csync,
                                            vout_pkg::csync_mode_e cm,
                                            vout_pkg::extra_mode_e em);
        expect_t e;
        logic csync;
        logic sog;
        if (s.osd_en) begin
            e.r = {$bits(vout_pkg::pix_t){s.osd_color[2]}};
            e.g = {$bits(vout_pkg::pix_t){s.osd_color[1]}};
            e.b = {$bits(vout_pkg::pix_t){s.osd_color[0]}};
        end else begin
            e.r = s.r;
            e.g = s.g;
            e.b = s.b;
        end
        // Low when either sync is low, or low when the two differ
        csync = (cm == vout_pkg::CSYNC_AND) ? (s.hs & s.vs) : (s.hs == s.vs);
        sog = (em == vout_pkg::EXTRA_RGSB) || (em == vout_pkg::EXTRA_YPBPR);
        e.hdmi_hs = hdmi_csync ? csync : s.hs;
        e.hdmi_vs = s.vs;
        e.de = s.de;
        e.vga_hs = (em == vout_pkg::EXTRA_RGBHV) ? s.hs : csync;
        e.vga_vs = (em == vout_pkg::EXTRA_RGBHV) ? s.vs : 1'b1;
        e.vga_blank_n = s.de;
        e.vga_sync_n = sog ? csync : 1'b0;
        return e;
    endfunction

    function automatic vout_pkg::resync_cnt_t next_resync_cnt(vout_pkg::resync_cnt_t cnt,
                                                             logic genlock);
        if (genlock) begin
            return '0;
        end
        if (cnt == '1) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_pix(input string name, input vout_pkg::pix_t exp_v,
                             input vout_pkg::pix_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
            note_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp_v, act_v);
            note_error();
        end
    endtask

    task automatic check_cnt(input string name, input vout_pkg::resync_cnt_t exp_v,
                             input vout_pkg::resync_cnt_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
            note_error();
        end
    endtask

    task automatic step();
        @(posedge pclk_out);
        #1;
    endtask

    task automatic drive_random();
        r_i = vout_pkg::pix_t'($urandom);
        g_i = vout_pkg::pix_t'($urandom);
        b_i = vout_pkg::pix_t'($urandom);
        hsync_i = 1'($urandom);
        vsync_i = 1'($urandom);
        de_i = 1'($urandom);
        osd_enable_i = 1'($urandom);
        osd_color_i = vout_pkg::osd_color_t'($urandom);
    endtask

    task automatic start_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d mismatches", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic load_cfg(input logic hcs, input vout_pkg::csync_mode_e cm,
                            input vout_pkg::exp_sel_e es, input vout_pkg::extra_mode_e em);
        int wait_cnt;
        step();
        cfg_hdmi_csync_i = hcs;
        cfg_csync_mode_i = cm;
        cfg_exp_sel_i = es;
        cfg_extra_mode_i = em;
        cfg_req_i = 1'b1;
        wait_cnt = 0;
        do begin
            step();
            wait_cnt++;
        end while (cfg_ack_o !== 1'b1 && wait_cnt < ack_limit);
        if (cfg_ack_o !== 1'b1) begin
            $display("config handshake: cfg_ack_o did not rise within %0d cycles", ack_limit);
            note_error();
        end
        cfg_req_i = 1'b0;
        wait_cnt = 0;
        do begin
            step();
            wait_cnt++;
        end while (cfg_ack_o !== 1'b0 && wait_cnt < ack_limit);
        if (cfg_ack_o !== 1'b0) begin
            $display("config handshake: cfg_ack_o did not fall within %0d cycles", ack_limit);
            note_error();
        end
        m_hdmi_csync = hcs;
        m_csync_mode = cm;
        m_exp_sel = es;
        m_extra_mode = em;
    endtask

    task automatic run_stream(input int n, input logic vga_on);
        hist.delete();
        chk_hdmi = 1'b1;
        chk_vga = vga_on;
        repeat (n) begin
            step();
            drive_random();
        end
        step();
        chk_hdmi = 1'b0;
        chk_vga = 1'b0;
    endtask

    task automatic send_frame(input logic genlock);
        step();
        out_sof_i = 1'b1;
        genlock_sof_i = genlock;
        step();
        out_sof_i = 1'b0;
        step();
        genlock_sof_i = 1'b0;
        m_resync_cnt = next_resync_cnt(m_resync_cnt, genlock);
        check_cnt("resync_cnt_o", m_resync_cnt, resync_cnt_o);
        check_bit("resync_o", m_resync_cnt == '1, resync_o);
        step();
    endtask

    // HDMI pins trail the sample by 2 cycles, VGA pins by 3
    always @(negedge pclk_out) begin
        if (chk_hdmi || chk_vga) begin
            cur_sample.r = r_i;
            cur_sample.g = g_i;
            cur_sample.b = b_i;
            cur_sample.hs = hsync_i;
            cur_sample.vs = vsync_i;
            cur_sample.de = de_i;
            cur_sample.osd_en = osd_enable_i;
            cur_sample.osd_color = osd_color_i;
            hist.push_front(cur_sample);
            if (hist.size() > 4) begin
                void'(hist.pop_back());
            end
            if (chk_hdmi && hist.size() >= 3) begin
                hdmi_exp = ref_outputs(hist[2], m_hdmi_csync, m_csync_mode, m_extra_mode);
                check_pix("hdmitx_r_o", hdmi_exp.r, hdmitx_r_o);
                check_pix("hdmitx_g_o", hdmi_exp.g, hdmitx_g_o);
                check_pix("hdmitx_b_o", hdmi_exp.b, hdmitx_b_o);
                check_bit("hdmitx_hsync_o", hdmi_exp.hdmi_hs, hdmitx_hsync_o);
                check_bit("hdmitx_vsync_o", hdmi_exp.hdmi_vs, hdmitx_vsync_o);
                check_bit("hdmitx_de_o", hdmi_exp.de, hdmitx_de_o);
                check_bit("vga_oe_o", m_exp_sel == vout_pkg::EXP_EXTRA_OUT, vga_oe_o);
            end
            if (chk_vga && hist.size() >= 4) begin
                vga_exp = ref_outputs(hist[3], m_hdmi_csync, m_csync_mode, m_extra_mode);
                check_pix("vga_r_o", vga_exp.r, vga_r_o);
                check_pix("vga_g_o", vga_exp.g, vga_g_o);
                check_pix("vga_b_o", vga_exp.b, vga_b_o);
                check_bit("vga_hs_o", vga_exp.vga_hs, vga_hs_o);
                check_bit("vga_vs_o", vga_exp.vga_vs, vga_vs_o);
                check_bit("vga_blank_n_o", vga_exp.vga_blank_n, vga_blank_n_o);
                check_bit("vga_sync_n_o", vga_exp.vga_sync_n, vga_sync_n_o);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge pclk_out);
            cycle_cnt++;
        end
        $display("timeout: simulation still running after %0d cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed_val = $urandom(32'h1054);
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        chk_hdmi = 1'b0;
        chk_vga = 1'b0;
        r_i = '0;
        g_i = '0;
        b_i = '0;
        hsync_i = 1'b1;
        vsync_i = 1'b1;
        de_i = 1'b0;
        osd_enable_i = 1'b0;
        osd_color_i = '0;
        cfg_req_i = 1'b0;
        cfg_hdmi_csync_i = 1'b0;
        cfg_csync_mode_i = vout_pkg::CSYNC_AND;
        cfg_exp_sel_i = vout_pkg::EXP_OFF;
        cfg_extra_mode_i = vout_pkg::EXTRA_RGBHV;
        out_sof_i = 1'b0;
        genlock_sof_i = 1'b0;
        m_hdmi_csync = 1'b0;
        m_csync_mode = vout_pkg::CSYNC_AND;
        m_exp_sel = vout_pkg::EXP_OFF;
        m_extra_mode = vout_pkg::EXTRA_RGBHV;
        m_resync_cnt = '0;

        // No clock edge yet since release, so every register shows its reset value
        wait (po_reset_n === 1'b1);
        #1;

        start_test();
        check_pix("hdmitx_r_o", '0, hdmitx_r_o);
        check_pix("hdmitx_g_o", '0, hdmitx_g_o);
        check_pix("hdmitx_b_o", '0, hdmitx_b_o);
        check_bit("hdmitx_hsync_o", 1'b1, hdmitx_hsync_o);
        check_bit("hdmitx_vsync_o", 1'b1, hdmitx_vsync_o);
        check_bit("hdmitx_de_o", 1'b0, hdmitx_de_o);
        check_pix("vga_r_o", '0, vga_r_o);
        check_pix("vga_g_o", '0, vga_g_o);
        check_pix("vga_b_o", '0, vga_b_o);
        check_bit("vga_hs_o", 1'b1, vga_hs_o);
        check_bit("vga_vs_o", 1'b1, vga_vs_o);
        check_bit("vga_blank_n_o", 1'b0, vga_blank_n_o);
        check_bit("vga_sync_n_o", 1'b0, vga_sync_n_o);
        check_bit("vga_oe_o", 1'b0, vga_oe_o);
        check_bit("cfg_ack_o", 1'b0, cfg_ack_o);
        check_bit("resync_o", 1'b0, resync_o);
        check_cnt("resync_cnt_o", '0, resync_cnt_o);
        end_test("reset values");

        start_test();
        run_stream(n_osd, 1'b0);
        end_test("osd overlay");

        start_test();
        for (int c = 0; c < 4; c++) begin
            load_cfg(c >= 2, vout_pkg::csync_mode_e'(c % 2), vout_pkg::EXP_OFF,
                     vout_pkg::EXTRA_RGBHV);
            run_stream(n_csync, 1'b0);
        end
        end_test("hdmi csync");

        start_test();
        for (int m = 0; m < 4; m++) begin
            load_cfg(1'b0, vout_pkg::csync_mode_e'(m % 2), vout_pkg::EXP_EXTRA_OUT,
                     vout_pkg::extra_mode_e'(m));
            run_stream(n_vga, 1'b1);
        end
        load_cfg(1'b0, vout_pkg::CSYNC_AND, vout_pkg::EXP_LEGACY_IN, vout_pkg::EXTRA_RGBHV);
        step();
        hold_r = vga_r_o;
        hold_g = vga_g_o;
        hold_b = vga_b_o;
        hold_hs = vga_hs_o;
        hold_vs = vga_vs_o;
        hold_blank_n = vga_blank_n_o;
        hold_sync_n = vga_sync_n_o;
        repeat (n_hold) begin
            step();
            drive_random();
            check_bit("vga_oe_o", 1'b0, vga_oe_o);
            check_pix("vga_r_o", hold_r, vga_r_o);
            check_pix("vga_g_o", hold_g, vga_g_o);
            check_pix("vga_b_o", hold_b, vga_b_o);
            check_bit("vga_hs_o", hold_hs, vga_hs_o);
            check_bit("vga_vs_o", hold_vs, vga_vs_o);
            check_bit("vga_blank_n_o", hold_blank_n, vga_blank_n_o);
            check_bit("vga_sync_n_o", hold_sync_n, vga_sync_n_o);
        end
        end_test("vga modes");

        start_test();
        step();
        cfg_hdmi_csync_i = 1'b0;
        cfg_csync_mode_i = vout_pkg::CSYNC_AND;
        cfg_exp_sel_i = vout_pkg::EXP_EXTRA_OUT;
        cfg_extra_mode_i = vout_pkg::EXTRA_RGSB;
        cfg_req_i = 1'b1;
        check_bit("cfg_ack_o", 1'b0, cfg_ack_o);
        step();
        check_bit("cfg_ack_o", 1'b1, cfg_ack_o);
        check_bit("vga_oe_o", 1'b1, vga_oe_o);
        cfg_req_i = 1'b0;
        step();
        check_bit("cfg_ack_o", 1'b0, cfg_ack_o);
        // Data lines move while req is low
        cfg_exp_sel_i = vout_pkg::EXP_OFF;
        cfg_extra_mode_i = vout_pkg::EXTRA_RGBHV;
        repeat (4) begin
            step();
            check_bit("cfg_ack_o", 1'b0, cfg_ack_o);
            check_bit("vga_oe_o", 1'b1, vga_oe_o);
        end
        end_test("config handshake");

        start_test();
        for (int f = 0; f < 10; f++) begin
            send_frame(1'b0);
        end
        send_frame(1'b1);
        send_frame(1'b0);
        end_test("resync monitor");

        step();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
hw/vout_pkg.sv
hw/vout_cfg_regs.sv
hw/osd_overlay.sv
hw/hdmi_tx_out.sv
hw/vga_dac_out.sv
hw/resync_monitor.sv
hw/vout_top.sv
test/tb_clk_gen.sv
test/tb_vout_top.sv

// ==== Bender.yml ====
package:
  name: vout_stage

export_include_dirs:
  - include

sources:
  - files:
      - hw/vout_pkg.sv
      - hw/vout_cfg_regs.sv
      - hw/osd_overlay.sv
      - hw/hdmi_tx_out.sv
      - hw/vga_dac_out.sv
      - hw/resync_monitor.sv
      - hw/vout_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_vout_top.sv
